// ==== src.f ====
+incdir+logic
logic/tile_pkg.sv
logic/mem_req_if.sv
logic/rx_fifo.sv
logic/rx_dispatch_fsm.sv
logic/store_counter.sv
logic/local_port_router.sv
logic/banked_mem.sv
logic/manycore_tile.sv
testbench/tile_checker.sv
testbench/tile_tb.sv

// ==== testbench/tile_tb.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module tile_tb;
   import tile_pkg::*;

   localparam int WAIT_LIMIT = 500;
   localparam int MEM_WORDS = `TILE_BANK_WORDS * `TILE_NUM_BANKS;
   localparam cord_t MY_X = 4'd3;
   localparam cord_t MY_Y = 4'd6;

   logic clk_i, reset_i;
   logic v_i, ready_o, v_o, ready_i;
   packet_t data_i, data_o;
   logic ret_v_i, ret_v_o, ret_ready_i;
   ret_packet_t ret_data_o;
   cord_t my_x_i, my_y_i;
   logic mem_v_i, mem_we_i, mem_yumi_o, mem_rv_o, freeze_o;
   addr_t mem_addr_i;
   data_t mem_wdata_i, mem_rdata_o;
   mask_t mem_mask_i;
   cnt_t out_stores_o;

   // reference model with memory indexed by unswizzled word index
   data_t model_mem [MEM_WORDS];
   packet_t exp_stores [$];
   data_t exp_reads [$];
   cnt_t exp_cnt;
   logic exp_freeze;
   integer seed = 8;
   int errors = 0;

   manycore_tile UUT (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic check_value(input string name, input logic [95:0] got,
                              input logic [95:0] exp);
      if (got !== exp)
      begin
         $display("Error: %s is %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   function automatic data_t merge_bytes(input data_t old, input data_t wdata, input mask_t mask);
      data_t res;
      res = old;
      for (int i = 0; i < `TILE_MASK_W; i++)
      begin
         if (mask[i])
            res[8*i +: 8] = wdata[8*i +: 8];
      end
      return res;
   endfunction

   // outgoing store built from a local request with bit 31 set
   function automatic packet_t expected_packet(input addr_t addr, input data_t wdata,
                                               input mask_t mask);
      packet_t p;
      p.op = `TILE_OP_STORE;
      p.addr = addr;
      p.addr[31:23] = '0;
      p.data = wdata;
      p.mask = mask;
      p.y_cord = addr[30:27];
      p.x_cord = addr[26:23];
      p.from_x_cord = MY_X;
      p.from_y_cord = MY_Y;
      return p;
   endfunction

   task automatic send_packet(input packet_t pkt);
      int t;
      t = 0;
      @(posedge clk_i);
      v_i <= 1'b1;
      data_i <= pkt;
      @(negedge clk_i);
      while (!ready_o && t < WAIT_LIMIT)
      begin
         @(negedge clk_i);
         t++;
      end
      if (!ready_o)
      begin
         $display("Timeout: the network input never accepted a packet");
         errors++;
      end
      @(posedge clk_i);
      v_i <= 1'b0;
   endtask

   task automatic local_access(input addr_t addr, input logic we, input data_t wdata,
                               input mask_t mask);
      int t;
      t = 0;
      @(posedge clk_i);
      mem_v_i <= 1'b1;
      mem_we_i <= we;
      mem_addr_i <= addr;
      mem_wdata_i <= wdata;
      mem_mask_i <= mask;
      @(negedge clk_i);
      while (!mem_yumi_o && t < WAIT_LIMIT)
      begin
         @(negedge clk_i);
         t++;
      end
      if (!mem_yumi_o)
      begin
         $display("Timeout: a local data request was never taken");
         errors++;
      end
      @(posedge clk_i);
      mem_v_i <= 1'b0;
   endtask

   task automatic random_request(input logic allow_remote);
      addr_t addr;
      data_t wdata;
      mask_t mask;
      addr = $random(seed);
      wdata = $random(seed);
      mask = $random(seed);
      if (!allow_remote)
         addr[31] = 1'b0;
      local_access(addr, addr[12], wdata, mask);
   endtask

   task automatic random_store();
      packet_t pkt;
      pkt.op = `TILE_OP_STORE;
      pkt.addr = $random(seed);
      pkt.data = $random(seed);
      pkt.mask = $random(seed);
      pkt.x_cord = MY_X;
      pkt.y_cord = MY_Y;
      pkt.from_x_cord = $random(seed);
      pkt.from_y_cord = $random(seed);
      send_packet(pkt);
   endtask

   // full sweep so every word goes through the read check
   task automatic read_all();
      for (int i = 0; i < MEM_WORDS; i++)
         local_access({20'b0, mem_idx_t'(i), 2'b00}, 1'b0, '0, '0);
   endtask

   task automatic pulse_returns(input int cycles);
      logic [31:0] r;
      repeat (cycles)
      begin
         @(posedge clk_i);
         r = $random(seed);
         ret_v_i <= (r[1:0] == 2'b00);
      end
      @(posedge clk_i);
      ret_v_i <= 1'b0;
   endtask

   // random stretches of back-pressure on both outgoing networks
   task automatic apply_pressure(input int cycles);
      int hold;
      logic [31:0] r;
      hold = 0;
      repeat (cycles)
      begin
         @(posedge clk_i);
         if (hold == 0)
         begin
            r = $random(seed);
            ready_i <= r[0];
            ret_ready_i <= r[1];
            hold = r[6:4];
         end
         else
            hold--;
      end
      @(posedge clk_i);
      ready_i <= 1'b1;
      ret_ready_i <= 1'b1;
   endtask

   task automatic drain();
      int t;
      t = 0;
      while ((exp_stores.size() != 0 || exp_reads.size() != 0) && t < WAIT_LIMIT)
      begin
         @(negedge clk_i);
         t++;
      end
      if (exp_stores.size() != 0 || exp_reads.size() != 0)
      begin
         $display("Timeout: returns or read data still missing");
         errors++;
      end
   endtask

   // scoreboard sampled mid-cycle where every output has settled
   always @(negedge clk_i)
   begin
      logic sent;
      packet_t st;
      mem_idx_t idx;
      if (!reset_i)
      begin
         // counter reflects all edges so far
         check_value("out_stores_o", out_stores_o, exp_cnt);
         if (mem_rv_o)
         begin
            if (exp_reads.size() == 0)
            begin
               $display("Read data appeared with no local read pending");
               errors++;
            end
            else
               check_value("mem_rdata_o", mem_rdata_o, exp_reads.pop_front());
         end
         sent = mem_v_i && mem_addr_i[31] && ready_i;
         check_value("v_o", v_o, mem_v_i && mem_addr_i[31]);
         if (sent)
            check_value("data_o", data_o, expected_packet(mem_addr_i, mem_wdata_i, mem_mask_i));
         // stores to the I/O row are not counted
         if (sent && mem_addr_i[30:27] != `TILE_IO_Y && !ret_v_i)
            exp_cnt++;
         else if (ret_v_i && !sent && exp_cnt != 0)
            exp_cnt--;
         if (mem_v_i && !mem_addr_i[31] && mem_yumi_o)
         begin
            idx = mem_addr_i[11:2];
            if (mem_we_i)
               model_mem[idx] = merge_bytes(model_mem[idx], mem_wdata_i, mem_mask_i);
            else
               exp_reads.push_back(model_mem[idx]);
         end
         if (ret_v_o)
         begin
            if (exp_stores.size() == 0)
            begin
               $display("Return packet sent with no remote store pending");
               errors++;
            end
            else
            begin
               st = exp_stores.pop_front();
               check_value("ret_data_o", ret_data_o, {st.from_y_cord, st.from_x_cord});
               model_mem[st.addr[11:2]] = merge_bytes(model_mem[st.addr[11:2]], st.data, st.mask);
            end
         end
         if (v_i && ready_o && data_i.op == `TILE_OP_STORE)
            exp_stores.push_back(data_i);
      end
   end

   initial
   begin
      packet_t pkt;
      logic [31:0] r;
      int t;
      reset_i <= 1'b1;
      v_i <= 1'b0;
      data_i <= '0;
      ready_i <= 1'b1;
      ret_v_i <= 1'b0;
      ret_ready_i <= 1'b1;
      my_x_i <= MY_X;
      my_y_i <= MY_Y;
      mem_v_i <= 1'b0;
      mem_we_i <= 1'b0;
      mem_addr_i <= '0;
      mem_wdata_i <= '0;
      mem_mask_i <= '0;
      exp_cnt = '0;
      exp_freeze = 1'b1;
      repeat (16) @(posedge clk_i);
      reset_i <= 1'b0;

      // state right after reset
      @(negedge clk_i);
      check_value("freeze_o", freeze_o, 1'b1);
      check_value("v_o", v_o, 1'b0);
      check_value("ret_v_o", ret_v_o, 1'b0);
      check_value("out_stores_o", out_stores_o, '0);
      check_value("ready_o", ready_o, 1'b1);

      // freeze and unfreeze packets with op 3 dropped
      for (int n = 0; n < 24; n++)
      begin
         r = $random(seed);
         pkt = '0;
         pkt.op = (r[1:0] == `TILE_OP_STORE) ? 2'd3 : r[1:0];
         pkt.from_x_cord = r[7:4];
         send_packet(pkt);
         if (pkt.op == `TILE_OP_FREEZE)
            exp_freeze = 1'b1;
         else if (pkt.op == `TILE_OP_UNFREEZE)
            exp_freeze = 1'b0;
         t = 0;
         @(negedge clk_i);
         while (freeze_o !== exp_freeze && t < WAIT_LIMIT)
         begin
            @(negedge clk_i);
            t++;
         end
         repeat (3)
         begin
            check_value("freeze_o", freeze_o, exp_freeze);
            @(negedge clk_i);
         end
      end

      // fill pattern depends on the whole word index
      for (int i = 0; i < MEM_WORDS; i++)
         local_access({20'b0, mem_idx_t'(i), 2'b00}, 1'b1, (i * 32'h9e3779b9) ^ 32'h5a5a0000, 4'hf);

      // local reads and writes
      repeat (200) random_request(1'b0);
      drain();

      // remote stores mixed with local traffic
      fork
         repeat (40) random_store();
         repeat (80) random_request(1'b0);
      join
      drain();
      read_all();
      drain();

      // surplus returns at zero leave the counter alone
      @(posedge clk_i);
      ret_v_i <= 1'b1;
      repeat (3) @(posedge clk_i);
      ret_v_i <= 1'b0;

      // outgoing stores with random returns
      fork
         repeat (100) random_request(1'b1);
         pulse_returns(300);
      join

      // four stores stuck behind the return network fill the FIFO
      @(posedge clk_i);
      ret_ready_i <= 1'b0;
      repeat (4) random_store();
      @(negedge clk_i);
      check_value("ready_o", ready_o, 1'b0);
      fork
         apply_pressure(200);
         repeat (20) random_store();
         repeat (60) random_request(1'b1);
      join
      drain();
      read_all();
      drain();

      errors += UUT.u_checker.fail_count;
      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// ==== testbench/tile_checker.sv ====
`timescale 1ns/1ps

module tile_checker (
   input logic                 clk_i,
   input logic                 reset_i,
   input logic                 ret_v_o,
   input logic                 ret_ready_i,
   input logic                 v_o,
   input tile_pkg::packet_t    data_o,
   input logic                 ready_i,
   input tile_pkg::cnt_t       out_stores_o,
   input logic                 mem_v_i,
   input logic                 mem_we_i,
   input tile_pkg::addr_t      mem_addr_i,
   input logic                 mem_yumi_o,
   input logic                 mem_rv_o
);

   int fail_count = 0;
   logic loc_read;

   // local read taken by the banked memory this cycle
   assign loc_read = mem_v_i & mem_yumi_o & ~mem_we_i & ~mem_addr_i[31];

   ret_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
      ret_v_o |-> ret_ready_i)
   else
   begin
      fail_count++;
      $error("return packet sent while the return network was not ready");
   end

   // outgoing packet held until the network takes it
   out_held: assert property (@(posedge clk_i) disable iff (reset_i)
      (v_o && !ready_i) |=> (v_o && $stable(data_o)))
   else
   begin
      fail_count++;
      $error("outgoing packet dropped or changed before ready");
   end

   // from zero the counter can only stay or step up
   cnt_no_wrap: assert property (@(posedge clk_i) disable iff (reset_i)
      (out_stores_o == '0) |=> (out_stores_o <= 1))
   else
   begin
      fail_count++;
      $error("store counter wrapped below zero");
   end

   read_latency: assert property (@(posedge clk_i) disable iff (reset_i)
      loc_read |=> mem_rv_o)
   else
   begin
      fail_count++;
      $error("read data did not follow a local read grant");
   end

   read_no_extra: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_rv_o |-> $past(loc_read))
   else
   begin
      fail_count++;
      $error("read valid without a local read one cycle before");
   end

endmodule

bind manycore_tile tile_checker u_checker (.*);

// ==== logic/manycore_tile.sv ====
`timescale 1ns/1ps

module manycore_tile (
   input  logic                  clk_i,
   input  logic                  reset_i,
   // incoming network
   input  logic                  v_i,
   input  tile_pkg::packet_t     data_i,
   output logic                  ready_o,
   // outgoing network
   output logic                  v_o,
   output tile_pkg::packet_t     data_o,
   input  logic                  ready_i,
   // return network
   input  logic                  ret_v_i,
   output logic                  ret_v_o,
   output tile_pkg::ret_packet_t ret_data_o,
   input  logic                  ret_ready_i,
   input  tile_pkg::cord_t       my_x_i,
   input  tile_pkg::cord_t       my_y_i,
   // core data port
   input  logic                  mem_v_i,
   input  logic                  mem_we_i,
   input  tile_pkg::addr_t       mem_addr_i,
   input  tile_pkg::data_t       mem_wdata_i,
   input  tile_pkg::mask_t       mem_mask_i,
   output logic                  mem_yumi_o,
   output logic                  mem_rv_o,
   output tile_pkg::data_t       mem_rdata_o,
   output logic                  freeze_o,
   output tile_pkg::cnt_t        out_stores_o
);
   import tile_pkg::*;

   // FIFO head toward the dispatcher
   logic fifo_v;
   packet_t fifo_data;
   logic fifo_yumi;
   // outgoing store report
   logic sent;
   cord_t sent_y;

   mem_req_if net_req ();
   mem_req_if loc_req ();

   rx_fifo u_rx_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (v_i),
      .data_i  (data_i),
      .ready_o (ready_o),
      .v_o     (fifo_v),
      .data_o  (fifo_data),
      .yumi_i  (fifo_yumi)
   );

   rx_dispatch_fsm u_rx_dispatch (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .head_v_i    (fifo_v),
      .head_i      (fifo_data),
      .head_yumi_o (fifo_yumi),
      .ret_ready_i (ret_ready_i),
      .ret_v_o     (ret_v_o),
      .ret_data_o  (ret_data_o),
      .freeze_o    (freeze_o),
      .net_req     (net_req.requester)
   );

   local_port_router u_router (
      .mem_v_i     (mem_v_i),
      .mem_we_i    (mem_we_i),
      .mem_addr_i  (mem_addr_i),
      .mem_wdata_i (mem_wdata_i),
      .mem_mask_i  (mem_mask_i),
      .mem_yumi_o  (mem_yumi_o),
      .my_x_i      (my_x_i),
      .my_y_i      (my_y_i),
      .v_o         (v_o),
      .data_o      (data_o),
      .ready_i     (ready_i),
      .sent_o      (sent),
      .sent_y_o    (sent_y),
      .loc_req     (loc_req.requester)
   );

   store_counter u_store_counter (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .sent_i   (sent),
      .sent_y_i (sent_y),
      .ret_v_i  (ret_v_i),
      .count_o  (out_stores_o)
   );

   banked_mem u_banked_mem (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .loc_req (loc_req.memory),
      .net_req (net_req.memory),
      .rv_o    (mem_rv_o),
      .rdata_o (mem_rdata_o)
   );

endmodule

// ==== logic/banked_mem.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module banked_mem (
   input  logic            clk_i,
   input  logic            reset_i,
   // local port wins on a bank conflict
   mem_req_if.memory       loc_req,
   mem_req_if.memory       net_req,
   output logic            rv_o,
   output tile_pkg::data_t rdata_o
);
   import tile_pkg::*;

   localparam int NB = `TILE_NUM_BANKS;
   localparam int BANK_W = $clog2(`TILE_NUM_BANKS);
   localparam int ROW_W = $clog2(`TILE_BANK_WORDS);

   logic [BANK_W-1:0] loc_bank;
   logic [BANK_W-1:0] net_bank;
   logic [ROW_W-1:0] loc_row;
   logic [ROW_W-1:0] net_row;
   logic [NB-1:0] loc_gnt;
   logic [NB-1:0] net_gnt;
   data_t bank_rdata [NB];
   logic rv_q;
   logic [BANK_W-1:0] rbank_q;

   // the low two index bits swapped pick the bank
   assign loc_bank = {loc_req.addr[0], loc_req.addr[1]};
   assign net_bank = {net_req.addr[0], net_req.addr[1]};
   assign loc_row = loc_req.addr[ROW_W+1:2];
   assign net_row = net_req.addr[ROW_W+1:2];

   for (genvar b = 0; b < NB; b++)
   begin : g_bank
      data_t mem_q [`TILE_BANK_WORDS];
      data_t rd_q;
      logic [ROW_W-1:0] row;
      logic we;
      data_t wdata;
      mask_t mask;

      // local first and network only on an idle bank
      assign loc_gnt[b] = loc_req.v && (loc_bank == BANK_W'(b));
      assign net_gnt[b] = net_req.v && (net_bank == BANK_W'(b)) && !loc_gnt[b];

      assign row = loc_gnt[b] ? loc_row : net_row;
      assign we = loc_gnt[b] ? loc_req.we : (net_gnt[b] & net_req.we);
      assign wdata = loc_gnt[b] ? loc_req.wdata : net_req.wdata;
      assign mask = loc_gnt[b] ? loc_req.mask : net_req.mask;

      always_ff @(posedge clk_i)
      begin
         if (we)
         begin
            // byte lanes under the mask
            for (int i = 0; i < `TILE_MASK_W; i++)
            begin
               if (mask[i])
               begin
                  mem_q[row][8*i +: 8] <= wdata[8*i +: 8];
               end
            end
         end
         // old data on a same-row write is never seen by a local read
         rd_q <= mem_q[row];
      end

      assign bank_rdata[b] = rd_q;
   end

   assign loc_req.yumi = |loc_gnt;
   assign net_req.yumi = |net_gnt;

   // read valid one cycle after a local read grant
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rv_q <= 1'b0;
      end
      else
      begin
         rv_q <= loc_req.yumi & ~loc_req.we;
      end
   end

   // remember which bank the local read went to
   always_ff @(posedge clk_i)
   begin
      rbank_q <= loc_bank;
   end

   assign rv_o = rv_q;
   assign rdata_o = bank_rdata[rbank_q];

endmodule

// ==== logic/local_port_router.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module local_port_router (
   // data request from the core
   input  logic              mem_v_i,
   input  logic              mem_we_i,
   input  tile_pkg::addr_t   mem_addr_i,
   input  tile_pkg::data_t   mem_wdata_i,
   input  tile_pkg::mask_t   mem_mask_i,
   output logic              mem_yumi_o,
   input  tile_pkg::cord_t   my_x_i,
   input  tile_pkg::cord_t   my_y_i,
   // outgoing network
   output logic              v_o,
   output tile_pkg::packet_t data_o,
   input  logic              ready_i,
   // report to the store counter
   output logic              sent_o,
   output tile_pkg::cord_t   sent_y_o,
   mem_req_if.requester      loc_req
);
   import tile_pkg::*;

   logic remote;

   // top address bit selects the network
   assign remote = mem_addr_i[`TILE_ADDR_W-1];

   // remote requests always go out as stores
   always_comb
   begin
      data_o.op = `TILE_OP_STORE;
      data_o.addr = {9'b0, mem_addr_i[22:0]};
      data_o.data = mem_wdata_i;
      data_o.mask = mem_mask_i;
      data_o.y_cord = mem_addr_i[30:27];
      data_o.x_cord = mem_addr_i[26:23];
      data_o.from_x_cord = my_x_i;
      data_o.from_y_cord = my_y_i;
   end

   assign v_o = mem_v_i & remote;
   assign sent_o = v_o & ready_i;
   assign sent_y_o = data_o.y_cord;

   // local path carries the word index only
   assign loc_req.v = mem_v_i & ~remote;
   assign loc_req.we = mem_we_i;
   assign loc_req.addr = mem_addr_i[11:2];
   assign loc_req.wdata = mem_wdata_i;
   assign loc_req.mask = mem_mask_i;

   assign mem_yumi_o = remote ? sent_o : loc_req.yumi;

endmodule

// ==== logic/store_counter.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module store_counter (
   input  logic            clk_i,
   input  logic            reset_i,
   // a store packet left the tile
   input  logic            sent_i,
   input  tile_pkg::cord_t sent_y_i,
   // a return packet came back
   input  logic            ret_v_i,
   output tile_pkg::cnt_t  count_o
);
   import tile_pkg::*;

   cnt_t count_q;
   logic inc;
   logic dec;

   // the I/O row never answers, so those stores are not tracked
   assign inc = sent_i & (sent_y_i != cord_t'(`TILE_IO_Y)) & ~ret_v_i;
   // send and return in one cycle cancel out
   assign dec = ret_v_i & ~sent_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         count_q <= '0;
      end
      else if (inc)
      begin
         count_q <= count_q + 1'b1;
      end
      else if (dec && (count_q != '0))
      begin
         // surplus return holds at zero
         count_q <= count_q - 1'b1;
      end
   end

   assign count_o = count_q;

endmodule

// ==== logic/rx_dispatch_fsm.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module rx_dispatch_fsm (
   input  logic                  clk_i,
   input  logic                  reset_i,
   // head of the receive FIFO
   input  logic                  head_v_i,
   input  tile_pkg::packet_t     head_i,
   output logic                  head_yumi_o,
   // return network
   input  logic                  ret_ready_i,
   output logic                  ret_v_o,
   output tile_pkg::ret_packet_t ret_data_o,
   output logic                  freeze_o,
   mem_req_if.requester          net_req
);
   import tile_pkg::*;

   tile_state_e state_q;
   tile_state_e state_d;
   logic is_store;
   logic is_freeze;
   logic is_unfreeze;
   logic is_unknown;

   // op decode of the head packet
   assign is_store = (head_i.op == `TILE_OP_STORE);
   assign is_freeze = (head_i.op == `TILE_OP_FREEZE);
   assign is_unfreeze = (head_i.op == `TILE_OP_UNFREEZE);
   assign is_unknown = ~(is_store | is_freeze | is_unfreeze);

   // freeze state moves only on freeze control packets
   always_comb
   begin
      state_d = state_q;
      if (head_v_i && is_freeze)
      begin
         state_d = TILE_FROZEN;
      end
      else if (head_v_i && is_unfreeze)
      begin
         state_d = TILE_RUNNING;
      end
   end

   // tile comes up frozen
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_q <= TILE_FROZEN;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   assign freeze_o = (state_q == TILE_FROZEN);

   // store request is held back while the return network is busy
   // so every committed store gets its return packet
   assign net_req.v = head_v_i & is_store & ret_ready_i;
   assign net_req.we = 1'b1;
   assign net_req.addr = head_i.addr[11:2];
   assign net_req.wdata = head_i.data;
   assign net_req.mask = head_i.mask;

   // control and unknown packets leave at once while stores leave on commit
   assign head_yumi_o = (head_v_i & (is_freeze | is_unfreeze | is_unknown)) | net_req.yumi;

   // one return per committed store
   assign ret_v_o = net_req.yumi;
   assign ret_data_o = '{y_cord: head_i.from_y_cord, x_cord: head_i.from_x_cord};

endmodule

// ==== logic/rx_fifo.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module rx_fifo (
   input  logic             clk_i,
   input  logic             reset_i,
   input  logic             v_i,
   input  tile_pkg::packet_t data_i,
   output logic             ready_o,
   output logic             v_o,
   output tile_pkg::packet_t data_o,
   input  logic             yumi_i
);
   import tile_pkg::*;

   localparam int PTR_W = $clog2(`TILE_FIFO_ELS);
   localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(`TILE_FIFO_ELS);

   // packet storage
   packet_t buf_q [`TILE_FIFO_ELS];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W:0] count_q;
   logic push;
   logic pop;

   assign ready_o = (count_q != FULL_CNT);
   assign v_o = (count_q != '0);
   // oldest entry sits at the read pointer
   assign data_o = buf_q[rd_ptr_q];

   assign push = v_i & ready_o;
   // yumi only comes while v_o is high
   assign pop = yumi_i;

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         buf_q[wr_ptr_q] <= data_i;
      end
   end

   // pointers wrap naturally since the depth is a power of two
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop)
         begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // push and pop together keep the count
         case ({push, pop})
            2'b10: count_q <= count_q + 1'b1;
            2'b01: count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

// ==== logic/mem_req_if.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

interface mem_req_if;

   // unswizzled word index width
   localparam int IDX_W = $clog2(`TILE_BANK_WORDS * `TILE_NUM_BANKS);

   logic v;
   logic we;
   logic [IDX_W-1:0] addr;
   logic [`TILE_DATA_W-1:0] wdata;
   logic [`TILE_MASK_W-1:0] mask;
   // memory takes the request in this cycle
   logic yumi;

   modport requester (output v, we, addr, wdata, mask, input yumi);
   modport memory (input v, we, addr, wdata, mask, output yumi);

endinterface

// ==== logic/tile_pkg.sv ====
`include "tile_consts.svh"

package tile_pkg;

   // plain vectors for the tile datapath
   typedef logic [`TILE_ADDR_W-1:0] addr_t;
   typedef logic [`TILE_DATA_W-1:0] data_t;
   typedef logic [`TILE_MASK_W-1:0] mask_t;
   typedef logic [`TILE_CORD_W-1:0] cord_t;
   typedef logic [1:0] op_t;
   typedef logic [`TILE_CNT_W-1:0] cnt_t;

   // word index into the whole banked memory before swizzle
   typedef logic [$clog2(`TILE_BANK_WORDS * `TILE_NUM_BANKS)-1:0] mem_idx_t;

   // network packet with op in the top bits
   typedef struct packed {
      op_t   op;
      addr_t addr;
      data_t data;
      mask_t mask;
      cord_t x_cord;
      cord_t y_cord;
      cord_t from_x_cord;
      cord_t from_y_cord;
   } packet_t;

   // return packet goes back to whoever sent the store
   typedef struct packed {
      cord_t y_cord;
      cord_t x_cord;
   } ret_packet_t;

   typedef enum logic {TILE_FROZEN, TILE_RUNNING} tile_state_e;

endpackage

// ==== logic/tile_consts.svh ====
`ifndef TILE_CONSTS_SVH
`define TILE_CONSTS_SVH

// datapath widths
`define TILE_ADDR_W 32
`define TILE_DATA_W 32
`define TILE_MASK_W 4
`define TILE_CORD_W 4

// receive buffering and local memory geometry
`define TILE_FIFO_ELS 4
`define TILE_NUM_BANKS 4
`define TILE_BANK_WORDS 256

// outstanding store counter
`define TILE_CNT_W 17
// returns never come back from this row
`define TILE_IO_Y 15

// packet op codes where op 3 is unknown
`define TILE_OP_STORE 2'd0
`define TILE_OP_FREEZE 2'd1
`define TILE_OP_UNFREEZE 2'd2

`endif
